//--- Makefile
TOP = dcacheTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- project.f
source/dcachePkg.sv
source/dcacheController.sv
source/cacheWordBank.sv
source/cacheTagArray.sv
source/dcache.sv
tests/dcacheTb.sv

//--- source/cacheTagArray.sv
`timescale 1ns/1ps

module cacheTagArray #(
  parameter int adrWidth  = dcachePkg::defaultAdrWidth,
  parameter int wordWidth = dcachePkg::defaultWordWidth,
  parameter int lineWords = dcachePkg::defaultLineWords,
  parameter int numLines  = dcachePkg::defaultNumLines
) (
  input  logic                           clk,
  input  logic                           reset,
  // Pipeline address
  input  logic [adrWidth-1:0]            adr,
  // Record tag and set valid for the addressed line
  input  logic                           tagWrite,
  // All bank outputs, bank 0 in the low word
  input  logic [lineWords*wordWidth-1:0] bankBus,
  // Line present with matching tag
  output logic                           hit,
  // Addressed word of the line
  output logic [wordWidth-1:0]           readData
);

  ////////////////////////////////////////
  // Address fields
  ////////////////////////////////////////

  localparam int byteOffsetWidth = $clog2(wordWidth / 8);
  localparam int wordOffsetWidth = $clog2(lineWords);
  localparam int offsetWidth = byteOffsetWidth + wordOffsetWidth;
  localparam int indexWidth = $clog2(numLines);
  // Everything above offset and index
  localparam int tagWidth = adrWidth - offsetWidth - indexWidth;

  logic [wordOffsetWidth-1:0] wordOffset;
  logic [indexWidth-1:0]      lineIndex;
  logic [tagWidth-1:0]        adrTag;

  assign wordOffset = adr[byteOffsetWidth +: wordOffsetWidth];
  assign lineIndex = adr[offsetWidth +: indexWidth];
  assign adrTag = adr[adrWidth-1 -: tagWidth];

  ////////////////////////////////////////
  // Tag and valid storage
  ////////////////////////////////////////

  logic [tagWidth-1:0] tags [numLines];
  // One valid bit per line
  logic [numLines-1:0] valid;

  // Tag of the addressed line recorded at the end of a fill
  always_ff @(posedge clk) begin
    if (tagWrite) begin
      tags[lineIndex] <= adrTag;
    end
  end

  // All lines invalid after reset so first accesses miss
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else if (tagWrite) begin
      valid[lineIndex] <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////

  // Direct mapped so a single compare
  assign hit = valid[lineIndex] && (tags[lineIndex] == adrTag);

  // Pick the addressed word out of the bank bus
  // Data is don't-care on a miss while stall is high
  assign readData = bankBus[wordOffset * wordWidth +: wordWidth];

endmodule

//--- source/cacheWordBank.sv
`timescale 1ns/1ps

module cacheWordBank #(
  parameter int wordWidth = dcachePkg::defaultWordWidth,
  parameter int numLines  = dcachePkg::defaultNumLines,
  parameter int lineWords = dcachePkg::defaultLineWords,
  // Word position within the line held by this bank
  parameter int bankIndex = 0
) (
  input  logic                         clk,
  // Line selected by the current address
  input  logic [$clog2(numLines)-1:0]  lineIndex,
  // Word position currently being fetched
  input  logic [$clog2(lineWords)-1:0] fillWord,
  input  logic                         fillEnable,
  // Word arriving from memory
  input  logic [wordWidth-1:0]         memReadData,
  // Stored word for lineIndex
  output logic [wordWidth-1:0]         bankData
);

  localparam int wordOffsetWidth = $clog2(lineWords);
  // This bank's position in fill counter terms
  localparam logic [wordOffsetWidth-1:0] myWord = wordOffsetWidth'(bankIndex);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // One word per line
  logic [wordWidth-1:0] mem [numLines];

  // Only the bank matching the fetch count takes the word
  logic bankWrite;

  assign bankWrite = fillEnable && (fillWord == myWord);

  always_ff @(posedge clk) begin
    if (bankWrite) begin
      mem[lineIndex] <= memReadData;
    end
  end

  ////////////////////////////////////////
  // Read
  ////////////////////////////////////////

  // Asynchronous read so hits return in the request cycle
  assign bankData = mem[lineIndex];

endmodule

//--- source/dcache.sv
`timescale 1ns/1ps

module dcache #(
  parameter int adrWidth  = dcachePkg::defaultAdrWidth,
  parameter int wordWidth = dcachePkg::defaultWordWidth,
  parameter int lineWords = dcachePkg::defaultLineWords,
  parameter int numLines  = dcachePkg::defaultNumLines
) (
  input  logic                 clk,
  input  logic                 reset,
  // Pipeline load port
  input  logic [adrWidth-1:0]  adr,
  input  logic                 read,
  output logic [wordWidth-1:0] readData,
  output logic                 stall,
  // Word-wide memory port
  output logic [adrWidth-1:0]  memAdr,
  output logic                 memRead,
  input  logic [wordWidth-1:0] memReadData,
  input  logic                 memAck
);

  localparam int byteOffsetWidth = $clog2(wordWidth / 8);
  localparam int wordOffsetWidth = $clog2(lineWords);
  localparam int offsetWidth = byteOffsetWidth + wordOffsetWidth;
  localparam int indexWidth = $clog2(numLines);

  ////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////

  logic                           hit;
  logic [wordOffsetWidth-1:0]     fillWord;
  logic                           fillEnable;
  logic                           tagWrite;
  // Index field shared by every bank
  logic [indexWidth-1:0]          lineIndex;
  // Bank outputs packed side by side
  logic [lineWords*wordWidth-1:0] bankBus;

  assign lineIndex = adr[offsetWidth +: indexWidth];

  // Miss detection and line fetch
  dcacheController #(
    .adrWidth (adrWidth),
    .wordWidth(wordWidth),
    .lineWords(lineWords)
  ) controller (
    .clk       (clk),
    .reset     (reset),
    .adr       (adr),
    .read      (read),
    .hit       (hit),
    .memAck    (memAck),
    .memAdr    (memAdr),
    .memRead   (memRead),
    .stall     (stall),
    .fillWord  (fillWord),
    .fillEnable(fillEnable),
    .tagWrite  (tagWrite)
  );

  // One bank per word position of the line
  for (genvar i = 0; i < lineWords; i++) begin : gBank
    cacheWordBank #(
      .wordWidth(wordWidth),
      .numLines (numLines),
      .lineWords(lineWords),
      .bankIndex(i)
    ) wordBank (
      .clk        (clk),
      .lineIndex  (lineIndex),
      .fillWord   (fillWord),
      .fillEnable (fillEnable),
      .memReadData(memReadData),
      .bankData   (bankBus[i*wordWidth +: wordWidth])
    );
  end

  // Tags, valid bits, hit and word select
  cacheTagArray #(
    .adrWidth (adrWidth),
    .wordWidth(wordWidth),
    .lineWords(lineWords),
    .numLines (numLines)
  ) tagArray (
    .clk     (clk),
    .reset   (reset),
    .adr     (adr),
    .tagWrite(tagWrite),
    .bankBus (bankBus),
    .hit     (hit),
    .readData(readData)
  );

endmodule

//--- source/dcacheController.sv
`timescale 1ns/1ps

module dcacheController #(
  parameter int adrWidth  = dcachePkg::defaultAdrWidth,
  parameter int wordWidth = dcachePkg::defaultWordWidth,
  parameter int lineWords = dcachePkg::defaultLineWords
) (
  input  logic                         clk,
  input  logic                         reset,
  // Pipeline load port
  input  logic [adrWidth-1:0]          adr,
  input  logic                         read,
  // Lookup result from the tag array
  input  logic                         hit,
  // Memory side
  input  logic                         memAck,
  output logic [adrWidth-1:0]          memAdr,
  output logic                         memRead,
  // Pipeline hold
  output logic                         stall,
  // Bank fill control
  output logic [$clog2(lineWords)-1:0] fillWord,
  output logic                         fillEnable,
  // Tag and valid update
  output logic                         tagWrite
);

  ////////////////////////////////////////
  // Address fields
  ////////////////////////////////////////

  // Byte offset inside one word
  localparam int byteOffsetWidth = $clog2(wordWidth / 8);
  // Word offset inside one line
  localparam int wordOffsetWidth = $clog2(lineWords);
  // Full offset inside one line
  localparam int offsetWidth = byteOffsetWidth + wordOffsetWidth;
  // Count value of the last word of a line
  localparam logic [wordOffsetWidth-1:0] lastWord = wordOffsetWidth'(lineWords - 1);

  dcachePkg::fetchStateT state;
  dcachePkg::fetchStateT nextState;

  // Load requested but line absent
  logic miss;
  // Ack for the final word of the line
  logic lastAck;

  assign miss = read && !hit;
  assign lastAck = fillEnable && (fillWord == lastWord);

  ////////////////////////////////////////
  // Fetch FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= dcachePkg::stIdle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      dcachePkg::stIdle: begin
        // Start a line fetch on any miss
        if (miss) begin
          nextState = dcachePkg::stFetch;
        end
      end
      dcachePkg::stFetch: begin
        // Stay until the whole line is in the banks
        if (lastAck) begin
          nextState = dcachePkg::stFill;
        end
      end
      dcachePkg::stFill: begin
        // One cycle for tag and valid before the access hits
        nextState = dcachePkg::stIdle;
      end
      default: begin
        nextState = dcachePkg::stIdle;
      end
    endcase
  end

  ////////////////////////////////////////
  // Word counter
  ////////////////////////////////////////

  // Advances once per ack and wraps to zero after the last word
  always_ff @(posedge clk) begin
    if (reset) begin
      fillWord <= '0;
    end else if (fillEnable) begin
      fillWord <= fillWord + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  // Request held high for the whole fetch so it waits on a slow ack
  assign memRead = (state == dcachePkg::stFetch);

  // Line-aligned address with the current word in the offset field
  // adr is held by the pipeline during the stall so this stays put
  assign memAdr = {adr[adrWidth-1:offsetWidth], fillWord, {byteOffsetWidth{1'b0}}};

  // Bank write strobe on each accepted word
  assign fillEnable = memRead && memAck;

  // Tag written once the data is complete
  assign tagWrite = (state == dcachePkg::stFill);

  // Hold on a miss in idle and for the whole fetch
  assign stall = (state != dcachePkg::stIdle) || miss;

endmodule

//--- source/dcachePkg.sv
package dcachePkg;

  ////////////////////////////////////////
  // Default cache geometry
  ////////////////////////////////////////

  // Byte address width seen by the pipeline and by memory
  localparam int defaultAdrWidth = 32;

  // Data word width in bits
  localparam int defaultWordWidth = 32;

  // Words per line as a power of two
  localparam int defaultLineWords = 4;

  // Number of lines as a power of two
  localparam int defaultNumLines = 16;

  ////////////////////////////////////////
  // Line fetch FSM
  ////////////////////////////////////////

  // stIdle   serving hits, waiting for a miss
  // stFetch  requesting one word per ack
  // stFill   writing tag and valid bit
  typedef enum logic [1:0] {
    stIdle,
    stFetch,
    stFill
  } fetchStateT;

endpackage

//--- tests/dcacheTb.sv
`timescale 1ns/1ps

module dcacheTb;

  ////////////////////////////////////////
  // Geometry and run length
  ////////////////////////////////////////

  localparam int adrWidth = dcachePkg::defaultAdrWidth;
  localparam int wordWidth = dcachePkg::defaultWordWidth;
  localparam int lineWords = dcachePkg::defaultLineWords;
  localparam int numLines = dcachePkg::defaultNumLines;

  localparam int byteOffW = $clog2(wordWidth / 8);
  localparam int wordOffW = $clog2(lineWords);
  localparam int offsetW = byteOffW + wordOffW;
  localparam int indexW = $clog2(numLines);
  localparam int tagW = adrWidth - offsetW - indexW;
  localparam logic [31:0] lineMask = ~((32'd1 << offsetW) - 32'd1);

  localparam int clkPeriod = 20;
  localparam int conflictAccesses = 8;
  localparam int randomAccesses = 300;
  localparam int totalAccesses = numLines + conflictAccesses + randomAccesses;
  // Four cycles per word at most, fill cycle, return to idle, idle gap
  localparam int worstCycles = lineWords * 4 + 2 + 2 + 4;
  localparam int timeoutNs = (totalAccesses * worstCycles + 50) * clkPeriod;

  logic                 clk;
  logic                 reset;
  logic [adrWidth-1:0]  adr;
  logic                 read;
  logic [wordWidth-1:0] readData;
  logic                 stall;
  logic [adrWidth-1:0]  memAdr;
  logic                 memRead;
  logic [wordWidth-1:0] memReadData;
  logic                 memAck;

  // Reference cache state
  logic [tagW-1:0] modelTag [numLines];
  logic            modelValid [numLines];

  logic [31:0] lfsr;
  int          hitCount;
  int          missCount;

  dcache #(
    .adrWidth (adrWidth),
    .wordWidth(wordWidth),
    .lineWords(lineWords),
    .numLines (numLines)
  ) dcache_inst (
    .clk        (clk),
    .reset      (reset),
    .adr        (adr),
    .read       (read),
    .readData   (readData),
    .stall      (stall),
    .memAdr     (memAdr),
    .memRead    (memRead),
    .memReadData(memReadData),
    .memAck     (memAck)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // Run length guard
  initial begin
    #(timeoutNs);
    $display("Testbench failed");
    $fatal(1, "Watchdog timeout because the cache never finished its accesses");
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1 stepped one bit at a time
  function automatic logic stepLfsr();
    logic feedback;
    feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], feedback};
    return feedback;
  endfunction

  function automatic logic [31:0] randBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], stepLfsr()};
    end
    return value;
  endfunction

  // Main memory contents as a fixed function of the word address
  function automatic logic [31:0] mixData(input logic [31:0] a);
    return (a * 32'h9e37_79b9) ^ (a >> 7) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic logic [31:0] makeAdr(input logic [31:0] tag, input logic [31:0] idx,
                                          input logic [31:0] wo);
    return (tag << (offsetW + indexW)) | (idx << offsetW) | (wo << byteOffW);
  endfunction

  function automatic logic [indexW-1:0] lineIndexOf(input logic [31:0] a);
    return a[offsetW +: indexW];
  endfunction

  function automatic logic [tagW-1:0] tagOf(input logic [31:0] a);
    return a[31 -: tagW];
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    $display("ERROR at %0t: %s expected 0x%08h got 0x%08h", $time, name, expected, actual);
    $display("Testbench failed");
    $fatal(1, "Stopped at the first error");
  endtask

  ////////////////////////////////////////
  // One load from request to completion
  ////////////////////////////////////////

  task automatic doAccess(input logic [31:0] a);
    logic [indexW-1:0] idx;
    logic [tagW-1:0]   tag;
    logic [31:0]       expAdr;
    logic              expHit;
    int                delay;
    @(posedge clk);
    adr <= a;
    read <= 1'b1;
    idx = lineIndexOf(a);
    tag = tagOf(a);
    expHit = modelValid[idx] && (modelTag[idx] == tag);
    // Stall is decided combinationally in the request cycle
    @(negedge clk);
    assert (stall === !expHit) else reportMismatch("stall", 32'(!expHit), 32'(stall));
    if (!expHit) begin
      missCount++;
      // One ascending request per word under a random ack delay
      for (int w = 0; w < lineWords; w++) begin
        expAdr = (a & lineMask) | (32'(w) << byteOffW);
        delay = int'(randBits(2));
        for (int d = 0; d <= delay; d++) begin
          @(posedge clk);
          if (d == delay) begin
            memAck <= 1'b1;
            memReadData <= mixData(expAdr);
          end else begin
            // Junk on the data bus while no ack
            memAck <= 1'b0;
            memReadData <= randBits(32);
          end
          @(negedge clk);
          assert (memRead === 1'b1) else reportMismatch("memRead", 32'd1, 32'(memRead));
          assert (memAdr === expAdr) else reportMismatch("memAdr", expAdr, memAdr);
          assert (stall === 1'b1) else reportMismatch("stall", 32'd1, 32'(stall));
        end
      end
      @(posedge clk);
      memAck <= 1'b0;
      @(negedge clk);
      // No further requests until the stall drops
      while (stall === 1'b1) begin
        assert (memRead === 1'b0) else reportMismatch("memRead", 32'd0, 32'(memRead));
        @(posedge clk);
        @(negedge clk);
      end
      modelValid[idx] = 1'b1;
      modelTag[idx] = tag;
    end else begin
      hitCount++;
    end
    // Completed access
    assert (stall === 1'b0) else reportMismatch("stall", 32'd0, 32'(stall));
    assert (readData === mixData(a)) else reportMismatch("readData", mixData(a), readData);
  endtask

  // Idle cycles between loads keep stall low
  task automatic idleGap();
    int gap;
    gap = int'(randBits(2));
    for (int g = 0; g < gap; g++) begin
      @(posedge clk);
      read <= 1'b0;
      adr <= randBits(32);
      @(negedge clk);
      assert (stall === 1'b0) else reportMismatch("stall", 32'd0, 32'(stall));
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] a;
    lfsr = 32'h1ce8;
    hitCount = 0;
    missCount = 0;
    reset = 1'b1;
    adr = '0;
    read = 1'b0;
    memReadData = '0;
    memAck = 1'b0;
    for (int i = 0; i < numLines; i++) begin
      modelValid[i] = 1'b0;
      modelTag[i] = '0;
    end

    // No memory request during the four reset cycles
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      if (i == 3) begin
        reset <= 1'b0;
      end
      @(negedge clk);
      assert (memRead === 1'b0) else reportMismatch("memRead", 32'd0, 32'(memRead));
    end

    // First touch of every line
    for (int i = 0; i < numLines; i++) begin
      a = makeAdr(randBits(2), 32'(i), randBits(wordOffW));
      doAccess(a);
      idleGap();
    end

    // Two tags on the same index evicting each other
    for (int i = 0; i < conflictAccesses; i++) begin
      a = makeAdr((i % 2 == 0) ? 32'd1 : 32'd2, 32'd5, randBits(wordOffW));
      doAccess(a);
    end

    // Random loads over a small tag range
    for (int i = 0; i < randomAccesses; i++) begin
      a = makeAdr(randBits(2), randBits(indexW), randBits(wordOffW));
      doAccess(a);
      idleGap();
    end

    @(posedge clk);
    read <= 1'b0;
    $display("Accesses done with %0d hits and %0d misses", hitCount, missCount);
    if (hitCount > 0 && missCount > 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("Stimulus produced no mix of hits and misses");
      $display("Testbench failed");
      $fatal(1, "Stopped on poor stimulus");
    end
  end

endmodule
